// File: compile.f
hw/ad_pkg.sv
hw/ad_us_tick.sv
hw/ad_clk_gen.sv
hw/ad_seq_fsm.sv
hw/ad_serial_rx.sv
hw/ad_sample_avg.sv
hw/ad_sample_top.sv
verification/adc_model.sv
verification/tb_ad_sample.sv

// File: hw/ad_clk_gen.sv
/* Serial clock and trigger divider */

module ad_clk_gen #(
	parameter int TRIG_US = 250
) (
	input  logic clk_sys,
	input  logic rst_n,
	input  logic pulse_us,
	output logic clk_5M,
	output logic clk_2_5M,
	output logic clk_2M,
	output logic clk_2kHz
);

	localparam int NUM_FAST = 3;
	localparam int TW = $clog2(TRIG_US + 1);

	// half periods in clk_sys cycles for 5, 2.5 and 2 MHz
	localparam logic [NUM_FAST-1:0][4:0] HALF_CYC = {5'd25, 5'd20, 5'd10};

	wire [NUM_FAST-1:0] fast_clk;
	logic [TW-1:0]      trig_cnt;

	// --------------------
	// fast serial clocks

	for (genvar i = 0; i < NUM_FAST; i++)
	begin : g_fast
		logic [4:0] div_cnt;
		logic       tgl;

		always_ff @(posedge clk_sys or negedge rst_n)
		begin
			if (!rst_n)
				div_cnt <= '0;
			else if (div_cnt == HALF_CYC[i] - 5'd1)
				div_cnt <= '0;
			else
				div_cnt <= div_cnt + 5'd1;
		end

		// flip on every counter restart
		always_ff @(posedge clk_sys or negedge rst_n)
		begin
			if (!rst_n)
				tgl <= 1'b0;
			else if (div_cnt == 5'd0)
				tgl <= ~tgl;
		end

		assign fast_clk[i] = tgl;
	end

	assign clk_5M   = fast_clk[0];
	assign clk_2_5M = fast_clk[1];
	assign clk_2M   = fast_clk[2];

	// --------------------
	// sample trigger counting microseconds

	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
			trig_cnt <= '0;
		else if (pulse_us)
			trig_cnt <= (trig_cnt == TW'(TRIG_US - 1)) ? '0 : trig_cnt + TW'(1);
	end

	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
			clk_2kHz <= 1'b0;
		else if (pulse_us && trig_cnt == '0)
			clk_2kHz <= ~clk_2kHz;
	end

endmodule

// File: hw/ad_pkg.sv
/* ADC front end shared types */

package ad_pkg;

	// adc word width
	localparam int ADC_BITS = 16;

	typedef logic [ADC_BITS-1:0] sample_t;

	// serial clock selection latched at the start of each readout
	typedef enum logic [1:0]
	{
		RATE_5M   = 2'd0,
		RATE_2_5M = 2'd1,
		RATE_2M   = 2'd2
	} rate_e;

	// conversion sequencer states
	typedef enum logic [1:0]
	{
		ST_IDLE  = 2'd0,
		ST_CONV  = 2'd1,
		ST_SHIFT = 2'd2,
		ST_STORE = 2'd3
	} seq_state_e;

endpackage

// File: hw/ad_sample_avg.sv
/* Sample block averager */

module ad_sample_avg #(
	parameter int AVG_LOG2 = 2
) (
	input  logic            clk_sys,
	input  logic            rst_n,
	input  logic            en,
	input  logic            store,
	input  ad_pkg::sample_t rx_data,
	output ad_pkg::sample_t sample,
	output logic            sample_valid,
	output ad_pkg::sample_t avg,
	output logic            avg_valid
);

	import ad_pkg::*;

	localparam int SW = ADC_BITS + AVG_LOG2;
	localparam int NW = (AVG_LOG2 > 0) ? AVG_LOG2 : 1;

	logic [SW-1:0] sum;
	logic [SW-1:0] sum_nxt;
	logic [NW-1:0] cnt;
	logic          blk_last;

	assign sum_nxt  = sum + SW'(rx_data);
	assign blk_last = (cnt == NW'((1 << AVG_LOG2) - 1));

	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
		begin
			sum          <= '0;
			cnt          <= '0;
			sample_valid <= 1'b0;
			avg_valid    <= 1'b0;
		end
		else
		begin
			sample_valid <= store;
			avg_valid    <= store && en && blk_last;
			if (!en)
			begin
				sum <= '0;
				cnt <= '0;
			end
			else if (store)
			begin
				// start the next block from zero
				sum <= blk_last ? '0 : sum_nxt;
				cnt <= blk_last ? '0 : cnt + NW'(1);
			end
		end
	end

	always_ff @(posedge clk_sys)
	begin
		if (store)
			sample <= rx_data;
		if (store && blk_last)
			avg <= sample_t'(sum_nxt >> AVG_LOG2);
	end

endmodule

// File: hw/ad_sample_top.sv
/* ADC sampling front end */

module ad_sample_top #(
	parameter int CLKS_PER_US = 100,
	parameter int TRIG_US     = 250,
	parameter int CONV_US     = 2,
	parameter int AVG_LOG2    = 2
) (
	input  logic            clk_sys,
	input  logic            rst_n,
	input  logic            en,
	input  ad_pkg::rate_e   rate,
	input  logic            adc_sdo,
	output logic            adc_sclk,
	output logic            adc_cs_n,
	output logic            adc_cnv,
	output ad_pkg::sample_t sample,
	output logic            sample_valid,
	output ad_pkg::sample_t avg,
	output logic            avg_valid
);

	import ad_pkg::*;

	logic    pulse_us;
	logic    clk_5M;
	logic    clk_2_5M;
	logic    clk_2M;
	logic    clk_2kHz;
	logic    rx_start;
	logic    rx_done;
	logic    store;
	sample_t rx_data;

	ad_us_tick #(
		.CLKS_PER_US (CLKS_PER_US)
	) u_us_tick (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.pulse_us (pulse_us)
	);

	ad_clk_gen #(
		.TRIG_US (TRIG_US)
	) u_clk_gen (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.pulse_us (pulse_us),
		.clk_5M   (clk_5M),
		.clk_2_5M (clk_2_5M),
		.clk_2M   (clk_2M),
		.clk_2kHz (clk_2kHz)
	);

	ad_seq_fsm #(
		.CONV_US (CONV_US)
	) u_seq_fsm (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.pulse_us (pulse_us),
		.clk_2kHz (clk_2kHz),
		.en       (en),
		.rx_done  (rx_done),
		.adc_cnv  (adc_cnv),
		.adc_cs_n (adc_cs_n),
		.rx_start (rx_start),
		.store    (store)
	);

	ad_serial_rx u_serial_rx (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.rx_start (rx_start),
		.rate     (rate),
		.clk_5M   (clk_5M),
		.clk_2_5M (clk_2_5M),
		.clk_2M   (clk_2M),
		.adc_sdo  (adc_sdo),
		.adc_sclk (adc_sclk),
		.rx_done  (rx_done),
		.rx_data  (rx_data)
	);

	ad_sample_avg #(
		.AVG_LOG2 (AVG_LOG2)
	) u_sample_avg (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.en           (en),
		.store        (store),
		.rx_data      (rx_data),
		.sample       (sample),
		.sample_valid (sample_valid),
		.avg          (avg),
		.avg_valid    (avg_valid)
	);

endmodule

// File: hw/ad_seq_fsm.sv
/* Conversion sequencer */

module ad_seq_fsm #(
	parameter int CONV_US = 2
) (
	input  logic clk_sys,
	input  logic rst_n,
	input  logic pulse_us,
	input  logic clk_2kHz,
	input  logic en,
	input  logic rx_done,
	output logic adc_cnv,
	output logic adc_cs_n,
	output logic rx_start,
	output logic store
);

	import ad_pkg::*;

	localparam int CW = $clog2(CONV_US + 1);

	seq_state_e    state;
	seq_state_e    state_nxt;
	logic          trig_q;
	logic          trig_rise;
	logic [CW-1:0] conv_cnt;
	logic          conv_last;

	assign trig_rise = clk_2kHz & ~trig_q;
	assign conv_last = pulse_us && (conv_cnt == CW'(CONV_US - 1));

	always_comb
	begin
		state_nxt = state;
		case (state)
			ST_IDLE:  if (en && trig_rise) state_nxt = ST_CONV;
			ST_CONV:  if (conv_last) state_nxt = ST_SHIFT;
			ST_SHIFT: if (rx_done) state_nxt = ST_STORE;
			ST_STORE: state_nxt = ST_IDLE;
			default:  state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state    <= ST_IDLE;
			trig_q   <= 1'b0;
			conv_cnt <= '0;
			rx_start <= 1'b0;
		end
		else
		begin
			state  <= state_nxt;
			trig_q <= clk_2kHz;
			// conversion time in whole microsecond ticks
			if (state != ST_CONV)
				conv_cnt <= '0;
			else if (pulse_us)
				conv_cnt <= conv_cnt + CW'(1);
			// one cycle pulse in the first cycle of ST_SHIFT
			rx_start <= (state == ST_CONV) && conv_last;
		end
	end

	// outputs straight from the state register
	assign adc_cnv  = (state == ST_CONV);
	assign adc_cs_n = (state != ST_SHIFT);
	assign store    = (state == ST_STORE);

endmodule

// File: hw/ad_serial_rx.sv
/* ADC serial receiver */

module ad_serial_rx (
	input  logic            clk_sys,
	input  logic            rst_n,
	input  logic            rx_start,
	input  ad_pkg::rate_e   rate,
	input  logic            clk_5M,
	input  logic            clk_2_5M,
	input  logic            clk_2M,
	input  logic            adc_sdo,
	output logic            adc_sclk,
	output logic            rx_done,
	output ad_pkg::sample_t rx_data
);

	import ad_pkg::*;

	localparam int BW = $clog2(ADC_BITS);

	rate_e         rate_q;
	logic          sel_clk;
	logic          pending;
	logic          busy;
	logic          sclk_q;
	logic          sclk_rise;
	logic          bit_last;
	logic [BW-1:0] bit_cnt;

	always_comb
	begin
		case (rate_q)
			RATE_2_5M: sel_clk = clk_2_5M;
			RATE_2M:   sel_clk = clk_2M;
			default:   sel_clk = clk_5M;
		endcase
	end

	assign sclk_rise = adc_sclk & ~sclk_q;
	assign bit_last  = (bit_cnt == BW'(ADC_BITS - 1));

	// --------------------
	// clock gating

	// busy opens only while the selected clock is low so the first edge is a full one
	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rate_q   <= RATE_5M;
			pending  <= 1'b0;
			busy     <= 1'b0;
			adc_sclk <= 1'b0;
			sclk_q   <= 1'b0;
		end
		else
		begin
			if (rx_start)
			begin
				rate_q  <= rate;
				pending <= 1'b1;
			end
			else if (pending && !sel_clk)
			begin
				pending <= 1'b0;
				busy    <= 1'b1;
			end
			else if (sclk_rise && bit_last)
				busy <= 1'b0;
			adc_sclk <= busy & sel_clk;
			sclk_q   <= adc_sclk;
		end
	end

	// --------------------
	// bit counter and shifter

	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
		begin
			bit_cnt <= '0;
			rx_done <= 1'b0;
		end
		else
		begin
			rx_done <= sclk_rise && bit_last;
			if (rx_start)
				bit_cnt <= '0;
			else if (sclk_rise)
				bit_cnt <= bit_last ? '0 : bit_cnt + BW'(1);
		end
	end

	// msb first
	always_ff @(posedge clk_sys)
	begin
		if (sclk_rise)
			rx_data <= {rx_data[ADC_BITS-2:0], adc_sdo};
	end

endmodule

// File: hw/ad_us_tick.sv
/* Microsecond tick */

module ad_us_tick #(
	parameter int CLKS_PER_US = 100
) (
	input  logic clk_sys,
	input  logic rst_n,
	output logic pulse_us
);

	localparam int CW = $clog2(CLKS_PER_US + 1);

	logic [CW-1:0] cyc_cnt;
	logic          cyc_wrap;

	assign cyc_wrap = (cyc_cnt == CW'(CLKS_PER_US - 1));

	// free running counter wrapping once per microsecond
	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
		begin
			cyc_cnt  <= '0;
			pulse_us <= 1'b0;
		end
		else
		begin
			cyc_cnt  <= cyc_wrap ? '0 : cyc_cnt + CW'(1);
			pulse_us <= cyc_wrap;
		end
	end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the ADC front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_ad_sample -f compile.f; then
	echo "verilator build failed"
	exit 1
fi

if ! sim_out=$(./obj_dir/Vtb_ad_sample); then
	echo "$sim_out"
	echo "simulation exited with an error status"
	exit 1
fi
echo "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx "NO ERRORS"; then
	exit 0
fi
echo "simulation reported failures"
exit 1

// File: verification/adc_model.sv
/* Serial ADC model */

module adc_model (
	input  logic            adc_sclk,
	input  logic            adc_cs_n,
	input  ad_pkg::sample_t word,
	output logic            adc_sdo
);

	timeunit 1ns;
	timeprecision 1ps;

	import ad_pkg::*;

	sample_t shift_q = '0;
	logic    sclk_q = 1'b0;

	assign adc_sdo = shift_q[ADC_BITS-1];

	// msb valid from the chip select fall and next bit on every sclk fall
	always @(negedge adc_cs_n or posedge adc_sclk or negedge adc_sclk)
	begin
		if (adc_sclk != sclk_q)
		begin
			if (!adc_sclk && !adc_cs_n)
				shift_q = {shift_q[ADC_BITS-2:0], 1'b0};
			sclk_q = adc_sclk;
		end
		else if (!adc_cs_n)
			shift_q = word;
	end

endmodule

// File: verification/tb_ad_sample.sv
/* ADC front end testbench */

module tb_ad_sample;

	timeunit 1ns;
	timeprecision 1ps;

	import ad_pkg::*;

	localparam int CLKS_PER_US = 10;
	localparam int TRIG_US     = 100;
	localparam int CONV_US     = 2;
	localparam int AVG_LOG2    = 2;
	localparam int AVG_N       = 1 << AVG_LOG2;
	localparam int CLK_PERIOD  = 40;
	localparam int NUM_ROWS    = 11;
	// one trigger period in clk_sys cycles
	localparam int TRIG_CYC    = 2 * TRIG_US * CLKS_PER_US;
	localparam int ROW_TIMEOUT = 2 * TRIG_CYC;
	localparam int WATCHDOG_NS = (NUM_ROWS + 2) * TRIG_CYC * CLK_PERIOD;
	localparam int CNV_MIN     = (CONV_US - 1) * CLKS_PER_US + 1;
	localparam int CNV_MAX     = CONV_US * CLKS_PER_US;

	logic    clk_sys = 1'b0;
	logic    rst_n = 1'b0;
	logic    en = 1'b0;
	rate_e   rate = RATE_5M;
	sample_t adc_word = '0;
	logic    adc_sdo;
	logic    adc_sclk;
	logic    adc_cs_n;
	logic    adc_cnv;
	sample_t sample;
	logic    sample_valid;
	sample_t avg;
	logic    avg_valid;

	// values applied on the next rising edge
	logic    rst_n_drv = 1'b0;
	logic    en_drv = 1'b0;
	rate_e   rate_drv = RATE_5M;
	sample_t word_drv = '0;

	// --------------------
	// stimulus table

	string   row_name [NUM_ROWS] = '{
		"rate_5m_a", "rate_2_5m_a", "rate_2m_a", "rate_5m_b", "rate_2_5m_b", "rate_2m_b",
		"en_low", "rate_5m_c", "rate_2m_c", "rate_2_5m_c", "rate_5m_d"
	};
	bit      row_en [NUM_ROWS] = '{
		1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1
	};
	rate_e   row_rate [NUM_ROWS] = '{
		RATE_5M, RATE_2_5M, RATE_2M, RATE_5M, RATE_2_5M, RATE_2M,
		RATE_5M, RATE_5M, RATE_2M, RATE_2_5M, RATE_5M
	};
	sample_t row_word [NUM_ROWS];

	integer  seed = 65;
	int      row_err = 0;
	int      err_cnt = 0;
	int      pass_cnt = 0;
	int      fail_cnt = 0;
	int      sw_sum = 0;
	int      sw_cnt = 0;

	// readout monitor state
	logic    cs_q = 1'b1;
	logic    cnv_q = 1'b0;
	logic    sclk_q = 1'b0;
	bit      edge_seen = 1'b0;
	bit      order_ok = 1'b0;
	int      cnv_run = 0;
	int      cnv_len = 0;
	int      cs_falls = 0;
	int      sv_total = 0;
	int      sclk_rises = 0;
	int      half_min = 0;
	int      half_max = 0;
	int      since = 0;

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	always @(posedge clk_sys)
	begin
		rst_n    <= rst_n_drv;
		en       <= en_drv;
		rate     <= rate_drv;
		adc_word <= word_drv;
	end

	ad_sample_top #(
		.CLKS_PER_US (CLKS_PER_US),
		.TRIG_US     (TRIG_US),
		.CONV_US     (CONV_US),
		.AVG_LOG2    (AVG_LOG2)
	) DUT (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.en           (en),
		.rate         (rate),
		.adc_sdo      (adc_sdo),
		.adc_sclk     (adc_sclk),
		.adc_cs_n     (adc_cs_n),
		.adc_cnv      (adc_cnv),
		.sample       (sample),
		.sample_valid (sample_valid),
		.avg          (avg),
		.avg_valid    (avg_valid)
	);

	adc_model u_adc_model (
		.adc_sclk (adc_sclk),
		.adc_cs_n (adc_cs_n),
		.word     (adc_word),
		.adc_sdo  (adc_sdo)
	);

	// --------------------
	// readout monitor sampling on the falling edge

	always @(negedge clk_sys)
	begin
		if (sample_valid)
			sv_total++;
		if (adc_cnv)
			cnv_run++;
		else if (cnv_q)
		begin
			cnv_len = cnv_run;
			cnv_run = 0;
		end
		if (cs_q && !adc_cs_n)
		begin
			cs_falls++;
			order_ok = !adc_cnv && cnv_q;
			sclk_rises = 0;
			half_min = ROW_TIMEOUT;
			half_max = 0;
			since = 0;
			edge_seen = 1'b0;
		end
		// half periods between sclk transitions while selected
		if (!adc_cs_n)
		begin
			since++;
			if (adc_sclk != sclk_q)
			begin
				if (edge_seen && since < half_min)
					half_min = since;
				if (edge_seen && since > half_max)
					half_max = since;
				if (adc_sclk)
					sclk_rises++;
				edge_seen = 1'b1;
				since = 0;
			end
		end
		cs_q = adc_cs_n;
		cnv_q = adc_cnv;
		sclk_q = adc_sclk;
	end

	function automatic int half_cycles(input rate_e r);
		case (r)
			RATE_2_5M: return 20;
			RATE_2M:   return 25;
			default:   return 10;
		endcase
	endfunction

	task automatic compare_value(input string test, input string what, input int expected,
		input int actual);
		assert (actual == expected)
		else
		begin
			$display("ERROR %s %s expected %0d actual %0d", test, what, expected, actual);
			row_err++;
		end
	endtask

	task automatic require(input string test, input bit cond, input string msg);
		assert (cond)
		else
		begin
			$display("%s: %s", test, msg);
			row_err++;
		end
	endtask

	task automatic wait_sample(output bit seen);
		int cyc;
		seen = 1'b0;
		cyc = 0;
		while (!seen && cyc < ROW_TIMEOUT)
		begin
			@(negedge clk_sys);
			cyc++;
			if (sample_valid)
				seen = 1'b1;
		end
	endtask

	task automatic apply_enabled_row(input int i);
		bit seen;
		int exp_avg;
		wait_sample(seen);
		if (!seen)
		begin
			require(row_name[i], 1'b0, "no sample_valid within the row timeout");
			return;
		end
		compare_value(row_name[i], "sample", int'(row_word[i]), int'(sample));
		compare_value(row_name[i], "sclk min half-period", half_cycles(row_rate[i]), half_min);
		compare_value(row_name[i], "sclk max half-period", half_cycles(row_rate[i]), half_max);
		compare_value(row_name[i], "sclk rising edges", ADC_BITS, sclk_rises);
		assert (cnv_len >= CNV_MIN && cnv_len <= CNV_MAX)
		else
		begin
			$display("ERROR %s adc_cnv high cycles expected %0d..%0d actual %0d",
				row_name[i], CNV_MIN, CNV_MAX, cnv_len);
			row_err++;
		end
		require(row_name[i], order_ok, "adc_cs_n did not fall right after adc_cnv fell");
		sw_sum += int'(row_word[i]);
		sw_cnt++;
		if (sw_cnt == AVG_N)
		begin
			exp_avg = sw_sum / AVG_N;
			require(row_name[i], avg_valid == 1'b1, "avg_valid missing at the end of a block");
			compare_value(row_name[i], "avg", exp_avg, int'(avg));
			sw_sum = 0;
			sw_cnt = 0;
		end
		else
			require(row_name[i], avg_valid == 1'b0, "avg_valid pulsed inside a block");
	endtask

	// nothing may start for two trigger periods while en is low
	task automatic hold_disabled_row(input int i);
		int falls_before;
		int sv_before;
		@(posedge clk_sys);
		falls_before = cs_falls;
		sv_before = sv_total;
		repeat (ROW_TIMEOUT) @(posedge clk_sys);
		compare_value(row_name[i], "adc_cs_n falls", falls_before, cs_falls);
		compare_value(row_name[i], "sample_valid pulses", sv_before, sv_total);
		sw_sum = 0;
		sw_cnt = 0;
		@(negedge clk_sys);
	endtask

	task automatic tally_test(input string test);
		if (row_err == 0)
		begin
			$display("PASS %s", test);
			pass_cnt++;
		end
		else
		begin
			$display("FAIL %s with %0d errors", test, row_err);
			fail_cnt++;
			err_cnt += row_err;
		end
	endtask

	initial
	begin
		for (int i = 0; i < NUM_ROWS; i++)
			row_word[i] = sample_t'($random(seed));
		repeat (3) @(negedge clk_sys);
		rst_n_drv = 1'b1;
		@(posedge clk_sys);
		@(negedge clk_sys);

		// idle outputs before the first trigger
		row_err = 0;
		require("reset_state", adc_cs_n == 1'b1, "adc_cs_n not high after reset");
		require("reset_state", adc_cnv == 1'b0, "adc_cnv not low after reset");
		require("reset_state", adc_sclk == 1'b0, "adc_sclk not low after reset");
		require("reset_state", sample_valid == 1'b0, "sample_valid not low after reset");
		require("reset_state", avg_valid == 1'b0, "avg_valid not low after reset");
		tally_test("reset_state");

		for (int i = 0; i < NUM_ROWS; i++)
		begin
			en_drv = row_en[i];
			rate_drv = row_rate[i];
			word_drv = row_word[i];
			row_err = 0;
			@(posedge clk_sys);
			if (row_en[i])
				apply_enabled_row(i);
			else
				hold_disabled_row(i);
			tally_test(row_name[i]);
		end

		$display("tests %0d, passed %0d, failed %0d, errors %0d",
			pass_cnt + fail_cnt, pass_cnt, fail_cnt, err_cnt);
		if (err_cnt == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

	// watchdog sized from the table length
	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, the run did not complete", WATCHDOG_NS);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule
